// File: logic/a25_wb_pkg.sv
// shared widths, state encoding and request payloads for the wishbone master
// the bus is fixed at 32 bits with byte lanes, line fills are four words
// request payloads are packed so a single holder module can carry either one

package a25_wb_pkg;

    // ============================
    // bus geometry
    // ============================
    localparam int WORD_W    = 32;
    localparam int SEL_W     = WORD_W / 8;
    localparam int BURST_LEN = 4;
    // number of address bits that step through one line fill
    localparam int BEAT_W    = $clog2(BURST_LEN);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [SEL_W-1:0]  sel_t;

    // burst1..burst3 wait for the first three beats of a line fill,
    // wait_ack waits for the last beat or the only beat of a single transfer
    typedef enum logic [2:0] {
        WB_IDLE     = 3'd0,
        WB_BURST1   = 3'd1,
        WB_BURST2   = 3'd2,
        WB_BURST3   = 3'd3,
        WB_WAIT_ACK = 3'd4
    } wb_state_t;

    // ============================
    // request payloads
    // ============================
    typedef struct packed {
        word_t address;
        logic  qword;
    } icache_req_t;

    // byte_enable only matters for writes, reads always use every lane
    typedef struct packed {
        word_t address;
        word_t write_data;
        sel_t  byte_enable;
        logic  write;
        logic  qword;
        logic  cached;
    } dcache_req_t;

endpackage

// File: logic/wb_req_hold.sv
// holds one outstanding cache request until the bus controller accepts it
// the requester must not pulse again before its previous request has been
// answered, so a new pulse never meets an older pending request
// the payload register has no reset, only the pending flag does

`timescale 1ns/1ps

module wb_req_hold
#(
    parameter type REQ_T = logic
)
(
    input  logic i_clk,
    input  logic quick_n_reset,

    // one-cycle request pulse with its payload valid in the same cycle
    input  logic i_req,
    input  REQ_T i_payload,

    // controller accepts the request in this cycle
    input  logic i_take,

    output logic o_pending,
    output REQ_T o_payload
);

    logic pending_r;
    REQ_T payload_r;

    // ============================
    // pending flag
    // ============================
    // a pulse sets the flag on the next edge, a take clears it on the next edge
    // the pulse wins if both ever arrive together so no request is lost
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            pending_r <= 1'b0;
        end
        else if (i_req)
        begin
            pending_r <= 1'b1;
        end
        else if (i_take)
        begin
            pending_r <= 1'b0;
        end
    end

    // payload is captured with the pulse and stays stable while the
    // controller runs the transfer, which reads address and flags from it
    always_ff @(posedge i_clk)
    begin
        if (i_req)
        begin
            payload_r <= i_payload;
        end
    end

    assign o_pending = pending_r;
    assign o_payload = payload_r;

endmodule

// File: logic/wb_bus_ctrl.sv
// wishbone bus state machine for the instruction and data cache requests
// data requests always win over instruction requests when both are pending
// qword reads become a four-beat burst wrapping inside an aligned 16-byte line,
// everything else is a single transfer
// no error input and no bus locking, cyc drops after every transfer
// ready pulses are combinational from the ack and only valid while stb is high

`timescale 1ns/1ps

module wb_bus_ctrl
    import a25_wb_pkg::*;
(
    input  logic        i_clk,
    input  logic        quick_n_reset,

    // requests held by the two request holders
    input  logic        i_icache_pending,
    input  icache_req_t i_icache,
    input  logic        i_dcache_pending,
    input  dcache_req_t i_dcache,

    // take pulses back to the holders
    output logic        o_icache_take,
    output logic        o_dcache_take,

    // wishbone master side
    output word_t       o_wb_adr,
    output sel_t        o_wb_sel,
    output logic        o_wb_we,
    output word_t       o_wb_dat,
    output logic        o_wb_cyc,
    output logic        o_wb_stb,
    input  word_t       i_wb_dat,
    input  logic        i_wb_ack,

    // ready pulses, one per word read or per completed write
    output logic        o_icache_ready,
    output logic        o_dcache_cached_ready,
    output logic        o_dcache_uncached_ready
);

    wb_state_t state_r;

    // which requester owns the transfer in progress
    logic      serve_icache_r;
    logic      serve_dcache_r;
    logic      serve_cached_r;

    logic      start_i;
    logic      start_d;
    logic      start;
    logic      beat_ack;
    logic      start_we;
    sel_t      start_sel;
    word_t     start_adr;
    logic      start_burst;

    // the two low address bits point at the first byte lane in use,
    // so a byte or halfword write carries a byte address on the bus
    function automatic logic [1:0] lane_offset(input sel_t sel);
        case (sel)
            4'b0010: return 2'd1;
            4'b0100: return 2'd2;
            4'b1000: return 2'd3;
            4'b1100: return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

    // ============================
    // arbitration
    // ============================
    // a start can only happen from idle, one cycle after the last ack at the
    // earliest, so there is always a gap with cyc low between transfers
    assign start_d = (state_r == WB_IDLE) && i_dcache_pending;
    assign start_i = (state_r == WB_IDLE) && i_icache_pending && !i_dcache_pending;
    assign start   = start_d || start_i;

    assign o_dcache_take = start_d;
    assign o_icache_take = start_i;

    // an ack only counts while a strobe is out on the bus
    assign beat_ack = o_wb_stb && i_wb_ack;

    // bus values for the transfer about to start
    always_comb
    begin
        start_we    = 1'b0;
        start_sel   = '1;
        // instruction fetches are always word aligned
        start_adr   = {i_icache.address[WORD_W-1:2], 2'b00};
        start_burst = i_icache.qword;

        if (start_d)
        begin
            start_we    = i_dcache.write;
            // reads fetch the whole word, writes only touch their lanes
            start_sel   = i_dcache.write ? i_dcache.byte_enable : '1;
            start_adr   = {i_dcache.address[WORD_W-1:2], lane_offset(start_sel)};
            // a qword write is not supported as a burst, it runs as a single
            start_burst = i_dcache.qword && !i_dcache.write;
        end
    end

    // ============================
    // state machine and bus registers
    // ============================
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state_r        <= WB_IDLE;
            o_wb_cyc       <= 1'b0;
            o_wb_stb       <= 1'b0;
            o_wb_we        <= 1'b0;
            o_wb_sel       <= '0;
            serve_icache_r <= 1'b0;
            serve_dcache_r <= 1'b0;
            serve_cached_r <= 1'b0;
        end
        else
        begin
            case (state_r)
                WB_IDLE:
                begin
                    if (start)
                    begin
                        o_wb_cyc       <= 1'b1;
                        o_wb_stb       <= 1'b1;
                        o_wb_we        <= start_we;
                        o_wb_sel       <= start_sel;
                        serve_icache_r <= start_i;
                        serve_dcache_r <= start_d;
                        // the cached flag only steers data readies
                        serve_cached_r <= start_d && i_dcache.cached;
                        state_r        <= start_burst ? WB_BURST1 : WB_WAIT_ACK;
                    end
                end

                // first three beats of a line fill, each ack moves to the
                // next word and the address wraps inside the line
                WB_BURST1:
                begin
                    if (beat_ack)
                    begin
                        state_r <= WB_BURST2;
                    end
                end

                WB_BURST2:
                begin
                    if (beat_ack)
                    begin
                        state_r <= WB_BURST3;
                    end
                end

                WB_BURST3:
                begin
                    if (beat_ack)
                    begin
                        state_r <= WB_WAIT_ACK;
                    end
                end

                // last beat of a burst or the only beat of a single transfer
                WB_WAIT_ACK:
                begin
                    if (beat_ack)
                    begin
                        o_wb_cyc       <= 1'b0;
                        o_wb_stb       <= 1'b0;
                        serve_icache_r <= 1'b0;
                        serve_dcache_r <= 1'b0;
                        serve_cached_r <= 1'b0;
                        state_r        <= WB_IDLE;
                    end
                end

                default:
                begin
                    o_wb_cyc <= 1'b0;
                    o_wb_stb <= 1'b0;
                    state_r  <= WB_IDLE;
                end
            endcase
        end
    end

    // address and write data are payload registers, they only move when a
    // transfer starts or when a burst beat is acknowledged
    always_ff @(posedge i_clk)
    begin
        if (start)
        begin
            o_wb_adr <= start_adr;
        end
        else if (beat_ack && (state_r == WB_BURST1 || state_r == WB_BURST2 ||
                              state_r == WB_BURST3))
        begin
            o_wb_adr[BEAT_W+1:2] <= o_wb_adr[BEAT_W+1:2] + BEAT_W'(1);
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (start_d)
        begin
            o_wb_dat <= i_dcache.write_data;
        end
    end

    // ============================
    // ready routing
    // ============================
    // every acknowledged beat goes to the requester that owns the transfer,
    // data beats are split by the cached flag recorded at the start
    assign o_icache_ready          = beat_ack && serve_icache_r;
    assign o_dcache_cached_ready   = beat_ack && serve_dcache_r && serve_cached_r;
    assign o_dcache_uncached_ready = beat_ack && serve_dcache_r && !serve_cached_r;

endmodule

// File: logic/a25_wishbone.sv
// wishbone master for the instruction and data caches of the core
// requests are one-cycle pulses, each is held until the bus can start it
// a requester must wait for the ready of its previous request before it
// pulses again, there is no other handshake
// read data is the bus data as is and is valid only while the matching ready
// is high, a write reports ready when its own ack arrives

`timescale 1ns/1ps

module a25_wishbone
    import a25_wb_pkg::*;
(
    input  logic  i_clk,
    input  logic  quick_n_reset,

    // instruction cache side
    input  logic  i_icache_req,
    input  logic  i_icache_qword,
    input  word_t i_icache_address,
    output word_t o_icache_read_data,
    output logic  o_icache_ready,

    // data cache side, the two request pulses are never high together
    input  logic  i_dcache_cached_req,
    input  logic  i_dcache_uncached_req,
    input  logic  i_dcache_qword,
    input  logic  i_dcache_write,
    input  word_t i_dcache_write_data,
    input  sel_t  i_dcache_byte_enable,
    input  word_t i_dcache_address,
    output word_t o_dcache_read_data,
    output logic  o_dcache_cached_ready,
    output logic  o_dcache_uncached_ready,

    // wishbone bus
    output word_t o_wb_adr,
    output sel_t  o_wb_sel,
    output logic  o_wb_we,
    input  word_t i_wb_dat,
    output word_t o_wb_dat,
    output logic  o_wb_cyc,
    output logic  o_wb_stb,
    input  logic  i_wb_ack
);

    icache_req_t icache_in;
    icache_req_t icache_held;
    dcache_req_t dcache_in;
    dcache_req_t dcache_held;
    logic        dcache_req;
    logic        icache_pending;
    logic        dcache_pending;
    logic        icache_take;
    logic        dcache_take;

    // ============================
    // request capture
    // ============================
    assign icache_in = '{address: i_icache_address, qword: i_icache_qword};

    // the cached flag comes from which of the two pulses fired
    assign dcache_req = i_dcache_cached_req || i_dcache_uncached_req;
    assign dcache_in  = '{address:     i_dcache_address,
                          write_data:  i_dcache_write_data,
                          byte_enable: i_dcache_byte_enable,
                          write:       i_dcache_write,
                          qword:       i_dcache_qword,
                          cached:      i_dcache_cached_req};

    wb_req_hold #(
        .REQ_T (icache_req_t)
    ) u_icache_hold (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_req         (i_icache_req),
        .i_payload     (icache_in),
        .i_take        (icache_take),
        .o_pending     (icache_pending),
        .o_payload     (icache_held)
    );

    wb_req_hold #(
        .REQ_T (dcache_req_t)
    ) u_dcache_hold (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_req         (dcache_req),
        .i_payload     (dcache_in),
        .i_take        (dcache_take),
        .o_pending     (dcache_pending),
        .o_payload     (dcache_held)
    );

    // ============================
    // bus controller
    // ============================
    wb_bus_ctrl u_bus_ctrl (
        .i_clk                   (i_clk),
        .quick_n_reset           (quick_n_reset),
        .i_icache_pending        (icache_pending),
        .i_icache                (icache_held),
        .i_dcache_pending        (dcache_pending),
        .i_dcache                (dcache_held),
        .o_icache_take           (icache_take),
        .o_dcache_take           (dcache_take),
        .o_wb_adr                (o_wb_adr),
        .o_wb_sel                (o_wb_sel),
        .o_wb_we                 (o_wb_we),
        .o_wb_dat                (o_wb_dat),
        .o_wb_cyc                (o_wb_cyc),
        .o_wb_stb                (o_wb_stb),
        .i_wb_dat                (i_wb_dat),
        .i_wb_ack                (i_wb_ack),
        .o_icache_ready          (o_icache_ready),
        .o_dcache_cached_ready   (o_dcache_cached_ready),
        .o_dcache_uncached_ready (o_dcache_uncached_ready)
    );

    // both caches see the bus data, each one only looks while its ready is up
    assign o_icache_read_data = i_wb_dat;
    assign o_dcache_read_data = i_wb_dat;

endmodule

// File: tb/tb_checks.svh
// compare tasks, error counters and the random source for the wishbone testbench
// included inside the testbench module, so it relies on the package import there
// every failing compare counts one value error, other faults count separately
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors = 0;
int other_errors = 0;

// ==============================
// value compares
// ==============================
task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp)
    begin
        $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        value_errors++;
    end
endtask

task automatic check_sel(input string what, input sel_t got, input sel_t exp);
    if (got !== exp)
    begin
        $display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        value_errors++;
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        value_errors++;
    end
endtask

// faults that are not a wrong value, like a ready on an output nobody waits on
task automatic report_fault(input string what);
    $display("Error at %0d ns: %s", $time, what);
    other_errors++;
endtask

// xorshift32, a zero state would stick so the seed must never be zero
function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

// File: tb/tb_a25_wishbone.sv
// testbench for the wishbone master with a 64-word slave memory
// the slave adds 0 to 2 random wait cycles before each ack
// a table of requests is applied one row at a time, a row can be paired with
// the next one so that both caches request in the same cycle
`timescale 1ns/1ps

module tb_a25_wishbone
    import a25_wb_pkg::*;
;

    localparam int ROWS         = 8;
    localparam int RESET_CYCLES = 5;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 40 * ROWS;
    localparam logic [1:0] K_ICACHE   = 2'd0;
    localparam logic [1:0] K_CACHED   = 2'd1;
    localparam logic [1:0] K_UNCACHED = 2'd2;

    typedef struct packed {
        logic [1:0] kind;
        logic       write;
        logic       qword;
        word_t      addr;
        sel_t       be;
        word_t      data;
        logic       together;
    } row_t;

    // one expected bus beat, with the write data on the bus or the read data
    // that the ready should carry
    typedef struct packed {
        word_t adr;
        sel_t  sel;
        logic  we;
        word_t dat;
    } beat_t;

    logic i_clk = 1'b0;
    logic quick_n_reset;
    logic i_icache_req, i_icache_qword;
    word_t i_icache_address;
    logic i_dcache_cached_req, i_dcache_uncached_req, i_dcache_qword, i_dcache_write;
    word_t i_dcache_write_data, i_dcache_address;
    sel_t i_dcache_byte_enable;
    word_t o_icache_read_data, o_dcache_read_data, o_wb_adr, o_wb_dat;
    logic o_icache_ready, o_dcache_cached_ready, o_dcache_uncached_ready;
    sel_t o_wb_sel;
    logic o_wb_we, o_wb_cyc, o_wb_stb;
    word_t i_wb_dat = '0;
    logic i_wb_ack = 1'b0;

    word_t mem [64];
    word_t ref_mem [64];
    row_t rows [ROWS];
    beat_t icache_q[$];
    beat_t cached_q[$];
    beat_t uncached_q[$];
    logic [31:0] rng = 32'h21132b2a;
    int wait_left = 0;
    int cycles = 0;
    int ready_count;
    logic prio_watch = 1'b0;
    int r;

    `include "tb_checks.svh"

    a25_wishbone u_dut (.*);

    always #50 i_clk = ~i_clk;

    // ==============================
    // slave memory model
    // ==============================
    // works 1 ns after the edge on the values the DUT just registered
    // an ack lasts one cycle per beat, and the next burst beat may be acked
    // straight away when its fresh wait count is zero
    always @(posedge i_clk)
    begin
        #1;
        if (i_wb_ack)
        begin
            i_wb_ack = 1'b0;
            rng = xorshift(rng);
            wait_left = int'(rng % 32'd3);
        end
        if (o_wb_cyc && o_wb_stb)
        begin
            if (wait_left == 0)
            begin
                i_wb_ack = 1'b1;
                i_wb_dat = mem[o_wb_adr[7:2]];
                if (o_wb_we)
                begin
                    for (int b = 0; b < SEL_W; b++)
                    begin
                        if (o_wb_sel[b])
                            mem[o_wb_adr[7:2]][8*b +: 8] = o_wb_dat[8*b +: 8];
                    end
                end
            end
            else
            begin
                wait_left--;
            end
        end
    end

    // a single enabled lane puts its own number on adr[1:0], the upper
    // halfword gives 2 and any other enable gives 0
    function automatic logic [1:0] first_lane(input sel_t sel);
        logic [1:0] lane;
        lane = 2'd0;
        if (sel == 4'b1100)
        begin
            lane = 2'd2;
        end
        else if ($onehot(sel))
        begin
            for (int b = 0; b < SEL_W; b++)
            begin
                if (sel[b])
                    lane = 2'(b);
            end
        end
        return lane;
    endfunction

    // compare one acknowledged beat with what the owner expected
    task automatic check_beat(input string who, input beat_t exp, input word_t rd);
        check_word({who, " adr"}, o_wb_adr, exp.adr);
        check_sel({who, " sel"}, o_wb_sel, exp.sel);
        check_flag({who, " we"}, o_wb_we, exp.we);
        if (exp.we)
            check_word({who, " write data"}, o_wb_dat, exp.dat);
        else
            check_word({who, " read data"}, rd, exp.dat);
    endtask

    // ==============================
    // ready monitor
    // ==============================
    always @(negedge i_clk)
    begin
        if (quick_n_reset)
        begin
            ready_count = int'(o_icache_ready) + int'(o_dcache_cached_ready)
                        + int'(o_dcache_uncached_ready);
            if (ready_count > 1)
                report_fault("more than one ready output is high at once");
            if (o_icache_ready)
            begin
                if (prio_watch && (cached_q.size() != 0 || uncached_q.size() != 0))
                    report_fault("icache ready came while a dcache request was unserved");
                if (icache_q.size() == 0)
                    report_fault("ready pulse on icache output with nothing expected");
                else
                    check_beat("icache", icache_q.pop_front(), o_icache_read_data);
            end
            if (o_dcache_cached_ready)
            begin
                if (cached_q.size() == 0)
                    report_fault("ready pulse on cached dcache output with nothing expected");
                else
                    check_beat("dcache cached", cached_q.pop_front(), o_dcache_read_data);
            end
            if (o_dcache_uncached_ready)
            begin
                if (uncached_q.size() == 0)
                    report_fault("ready pulse on uncached dcache output with nothing expected");
                else
                    check_beat("dcache uncached", uncached_q.pop_front(), o_dcache_read_data);
            end
        end
    end

    // drive one row onto the cache ports and queue the beats it should produce
    task automatic issue(input row_t row);
        beat_t bt;
        logic [1:0] off;
        int n;
        n = (row.qword && !row.write) ? BURST_LEN : 1;
        for (int i = 0; i < n; i++)
        begin
            off = row.addr[3:2] + 2'(i);
            bt.we = row.write;
            bt.sel = row.write ? row.be : 4'b1111;
            bt.adr = {row.addr[31:4], off, 2'b00};
            if (row.kind != K_ICACHE)
                bt.adr[1:0] = first_lane(bt.sel);
            bt.dat = row.write ? row.data : ref_mem[bt.adr[7:2]];
            if (row.kind == K_ICACHE)
                icache_q.push_back(bt);
            else if (row.kind == K_CACHED)
                cached_q.push_back(bt);
            else
                uncached_q.push_back(bt);
        end
        if (row.write)
        begin
            for (int b = 0; b < SEL_W; b++)
            begin
                if (row.be[b])
                    ref_mem[row.addr[7:2]][8*b +: 8] = row.data[8*b +: 8];
            end
        end
        if (row.kind == K_ICACHE)
        begin
            i_icache_req = 1'b1;
            i_icache_qword = row.qword;
            i_icache_address = row.addr;
        end
        else
        begin
            i_dcache_cached_req = (row.kind == K_CACHED);
            i_dcache_uncached_req = (row.kind == K_UNCACHED);
            i_dcache_write = row.write;
            i_dcache_qword = row.qword;
            i_dcache_address = row.addr;
            i_dcache_byte_enable = row.be;
            i_dcache_write_data = row.data;
        end
    endtask

    // ==============================
    // timeout
    // ==============================
    always @(posedge i_clk)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout: the DUT did not return every expected ready in time");
            $display("Test FAILED");
            $finish;
        end
    end

    initial
    begin
        for (int i = 0; i < 64; i++)
        begin
            mem[i] = word_t'(i) ^ 32'hA5A5_0000;
            ref_mem[i] = word_t'(i) ^ 32'hA5A5_0000;
        end
        // kind, write, qword, address, byte enable, data, paired with next row
        rows[0] = '{K_ICACHE,   1'b0, 1'b0, 32'h15, 4'h0, 32'h0, 1'b0};
        rows[1] = '{K_ICACHE,   1'b0, 1'b1, 32'h28, 4'h0, 32'h0, 1'b0};
        rows[2] = '{K_CACHED,   1'b1, 1'b0, 32'h40, 4'b0010, 32'h1234_5678, 1'b0};
        rows[3] = '{K_CACHED,   1'b0, 1'b0, 32'h40, 4'h0, 32'h0, 1'b0};
        rows[4] = '{K_UNCACHED, 1'b0, 1'b0, 32'h50, 4'h0, 32'h0, 1'b0};
        rows[5] = '{K_UNCACHED, 1'b0, 1'b1, 32'h64, 4'h0, 32'h0, 1'b0};
        rows[6] = '{K_ICACHE,   1'b0, 1'b0, 32'h80, 4'h0, 32'h0, 1'b1};
        rows[7] = '{K_CACHED,   1'b0, 1'b1, 32'h90, 4'h0, 32'h0, 1'b0};

        quick_n_reset = 1'b0;
        i_icache_req = 1'b0;
        i_icache_qword = 1'b0;
        i_icache_address = '0;
        i_dcache_cached_req = 1'b0;
        i_dcache_uncached_req = 1'b0;
        i_dcache_qword = 1'b0;
        i_dcache_write = 1'b0;
        i_dcache_write_data = '0;
        i_dcache_byte_enable = '0;
        i_dcache_address = '0;

        // bus and readies stay quiet through reset and the cycle after it
        // reset is released just after the fifth rising edge
        for (int c = 0; c <= RESET_CYCLES; c++)
        begin
            if (c == RESET_CYCLES - 1)
            begin
                @(posedge i_clk);
                #1;
                quick_n_reset = 1'b1;
            end
            @(negedge i_clk);
            check_flag("cyc", o_wb_cyc, 1'b0);
            check_flag("stb", o_wb_stb, 1'b0);
            check_flag("icache ready", o_icache_ready, 1'b0);
            check_flag("cached ready", o_dcache_cached_ready, 1'b0);
            check_flag("uncached ready", o_dcache_uncached_ready, 1'b0);
            if (c == RESET_CYCLES - 1)
            begin
                check_flag("we", o_wb_we, 1'b0);
                check_sel("sel", o_wb_sel, 4'b0000);
            end
        end

        r = 0;
        while (r < ROWS)
        begin
            @(posedge i_clk);
            #1;
            issue(rows[r]);
            if (rows[r].together)
            begin
                prio_watch = 1'b1;
                issue(rows[r+1]);
                r += 2;
            end
            else
            begin
                r += 1;
            end
            @(posedge i_clk);
            #1;
            i_icache_req = 1'b0;
            i_dcache_cached_req = 1'b0;
            i_dcache_uncached_req = 1'b0;
            while (icache_q.size() != 0 || cached_q.size() != 0 || uncached_q.size() != 0)
                @(posedge i_clk);
            prio_watch = 1'b0;
            // the bus is looked at mid-cycle where cyc is settled
            @(negedge i_clk);
            while (o_wb_cyc)
                @(negedge i_clk);
        end

        repeat (3) @(posedge i_clk);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+tb
logic/a25_wb_pkg.sv
logic/wb_req_hold.sv
logic/wb_bus_ctrl.sv
logic/a25_wishbone.sv
tb/tb_a25_wishbone.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_a25_wishbone -o sim_tb \
    > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "^Test OK$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
